// ==== bars/bar_colour.sv ====
/*
 * raster-bar colour generator, steps brightness up and down every few lines
 * updates once per line at the start of horizontal blanking
 */

`timescale 1ns/10ps

module bar_colour
    import raster_pkg::*;
(
    input  logic   clk_pix,
    input  logic   rst,
    input  coord_t sx,            // current column
    input  coord_t sy,            // current line
    input  logic   palette_gold,  // 1 selects gold start, 0 blue
    output colr_t  bar_colr       // colour for the next active line
);

    // brightness direction
    typedef enum logic {
        BRIGHTEN,
        DIM
    } dir_t;

    dir_t      dir;
    dir_t      dir_next;
    colr_t     colr_next;
    colr_t     start_colr;     // restart colour from the palette input
    colr_cnt_t cnt_colr;       // steps taken in this half bar
    colr_cnt_t cnt_colr_next;
    line_cnt_t cnt_line;       // lines drawn in this colour
    line_cnt_t cnt_line_next;
    logic      line_tick;      // start of blanking on this line
    logic      frame_restart;  // last line of the frame

    assign start_colr    = palette_gold ? COLR_GOLD : COLR_BLUE;
    assign line_tick     = (sx == H_RES);
    assign frame_restart = (sy == V_LAST);

    always_comb begin
        // hold by default
        dir_next      = dir;
        colr_next     = bar_colr;
        cnt_colr_next = cnt_colr;
        cnt_line_next = cnt_line;

        if (line_tick) begin
            if (frame_restart) begin
                // back to the start colour for line 0
                dir_next      = BRIGHTEN;
                colr_next     = start_colr;
                cnt_colr_next = '0;
                cnt_line_next = '0;
            end else if (cnt_line == LINE_LAST) begin
                cnt_line_next = '0;  // colour done
                if (cnt_colr == COLR_LAST) begin
                    // half bar complete, turn round without changing colour
                    cnt_colr_next = '0;
                    case (dir)
                        BRIGHTEN: dir_next = DIM;
                        DIM:      dir_next = BRIGHTEN;
                        default:  dir_next = BRIGHTEN;
                    endcase
                end else begin
                    cnt_colr_next = cnt_colr + 1'b1;
                    case (dir)
                        BRIGHTEN: colr_next = bar_colr + COLR_STEP;  // one step brighter
                        DIM:      colr_next = bar_colr - COLR_STEP;  // one step darker
                        default:  colr_next = bar_colr;
                    endcase
                end
            end else begin
                cnt_line_next = cnt_line + 1'b1;  // same colour, another line
            end
        end
    end

    // reset lands in the same state as a frame restart
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            dir      <= BRIGHTEN;
            bar_colr <= start_colr;
            cnt_colr <= '0;
            cnt_line <= '0;
        end else begin
            dir      <= dir_next;
            bar_colr <= colr_next;
            cnt_colr <= cnt_colr_next;
            cnt_line <= cnt_line_next;
        end
    end

endmodule

// ==== common/raster_pkg.sv ====
/*
 * shared constants and types for the 720p raster-bar demo
 * imported by every design block and by the testbench
 */

package raster_pkg;

    // vector types with a meaning of their own
    typedef logic [11:0] coord_t;     // screen coordinate, wide enough for 1650 x 750
    typedef logic [11:0] colr_t;      // 12-bit colour as {red, green, blue}
    typedef logic [3:0]  chan_t;      // one 4-bit colour channel
    typedef logic [7:0]  dvi_chan_t;  // one 8-bit output channel

    // horizontal timing in pixels (1280x720 at 60 Hz)
    localparam coord_t H_RES   = 12'd1280;  // active pixels
    localparam coord_t H_FP    = 12'd110;   // front porch
    localparam coord_t H_SYNC  = 12'd40;    // sync pulse
    localparam coord_t H_BP    = 12'd220;   // back porch
    localparam coord_t H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 1650

    // vertical timing in lines
    localparam coord_t V_RES   = 12'd720;
    localparam coord_t V_FP    = 12'd5;
    localparam coord_t V_SYNC  = 12'd5;
    localparam coord_t V_BP    = 12'd20;
    localparam coord_t V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 750

    // derived counter positions
    localparam coord_t H_LAST = H_TOTAL - 12'd1;            // last column of a line
    localparam coord_t V_LAST = V_TOTAL - 12'd1;            // last line of a frame
    localparam coord_t HS_STA = H_RES + H_FP;               // first hsync column
    localparam coord_t HS_END = H_RES + H_FP + H_SYNC - 12'd1;
    localparam coord_t VS_STA = V_RES + V_FP;               // first vsync line
    localparam coord_t VS_END = V_RES + V_FP + V_SYNC - 12'd1;

    localparam logic SYNC_POL = 1'b1;  // 720p uses positive sync

    // raster bar look
    localparam colr_t COLR_BLUE = 12'h126;  // blue start colour
    localparam colr_t COLR_GOLD = 12'h640;  // gold start colour
    localparam colr_t COLR_STEP = 12'h111;  // one brightness step on all channels
    localparam int    COLR_NUM  = 10;       // colour steps per half bar
    localparam int    LINE_NUM  = 4;        // lines drawn in each colour

    // bar counter widths and terminal values
    localparam int COLR_CNT_W = $clog2(COLR_NUM);
    localparam int LINE_CNT_W = $clog2(LINE_NUM);

    typedef logic [COLR_CNT_W-1:0] colr_cnt_t;  // counts colour steps
    typedef logic [LINE_CNT_W-1:0] line_cnt_t;  // counts lines within one colour

    localparam colr_cnt_t COLR_LAST = colr_cnt_t'(COLR_NUM - 1);
    localparam line_cnt_t LINE_LAST = line_cnt_t'(LINE_NUM - 1);

endpackage

// ==== display/display_timing.sv ====
/*
 * 1280x720 display timing, position counters plus registered sync and de
 * all outputs come from the same register stage so they stay aligned
 */

`timescale 1ns/10ps

module display_timing
    import raster_pkg::*;
(
    input  logic   clk_pix,  // pixel clock
    input  logic   rst,      // sync reset, active high
    output coord_t sx,       // horizontal position
    output coord_t sy,       // vertical position
    output logic   hsync,
    output logic   vsync,
    output logic   de        // data enable, high in the active area
);

    coord_t sx_next;      // position for the coming cycle
    coord_t sy_next;
    logic   line_end;     // last column of the line
    logic   frame_end;    // last line of the frame
    logic   hsync_next;
    logic   vsync_next;
    logic   de_next;

    // counter advance
    always_comb begin
        line_end  = (sx == H_LAST);
        frame_end = (sy == V_LAST);

        sx_next = line_end ? '0 : sx + 1'b1;  // wrap at H_TOTAL

        // vertical steps only on the line wrap
        if (line_end) begin
            sy_next = frame_end ? '0 : sy + 1'b1;
        end else begin
            sy_next = sy;
        end
    end

    // decode from next position so flops line up with sx and sy
    always_comb begin
        if (sx_next >= HS_STA && sx_next <= HS_END) begin
            hsync_next = SYNC_POL;
        end else begin
            hsync_next = ~SYNC_POL;
        end

        if (sy_next >= VS_STA && sy_next <= VS_END) begin
            vsync_next = SYNC_POL;
        end else begin
            vsync_next = ~SYNC_POL;
        end

        de_next = (sx_next < H_RES) && (sy_next < V_RES);  // active area only
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= ~SYNC_POL;  // sync idle
            vsync <= ~SYNC_POL;
            de    <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= hsync_next;
            vsync <= vsync_next;
            de    <= de_next;
        end
    end

endmodule

// ==== sim.f ====
+incdir+sim
common/raster_pkg.sv
display/display_timing.sv
bars/bar_colour.sv
src/video_out.sv
src/rasterbars_top.sv
sim/tb_rasterbars.sv

// ==== sim/tb_model.svh ====
/*
 * reference model and check helpers for the raster-bar testbench
 * included inside the testbench module, relies on its raster_pkg import
 */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int checks_done = 0;  // compares made so far
int errors_seen = 0;  // compares that failed

// expected bar colour for active line `line` of a frame that restarted at `start`
// walks the per-line rule once for every line that ended before this one
function automatic colr_t bar_colour_ref(input int line, input colr_t start);
    colr_t colr;
    logic  dimming;   // direction, 0 while brightening
    int    steps;     // colour steps taken in this half bar
    int    lines;     // lines already drawn in this colour
    int    i;
    colr    = start;
    dimming = 1'b0;
    steps   = 0;
    lines   = 0;
    for (i = 0; i < line; i++) begin
        if (lines == LINE_NUM - 1) begin
            lines = 0;
            if (steps == COLR_NUM - 1) begin
                dimming = ~dimming;  // turn round, colour kept
                steps   = 0;
            end else begin
                colr  = dimming ? colr - COLR_STEP : colr + COLR_STEP;
                steps = steps + 1;
            end
        end else begin
            lines = lines + 1;
        end
    end
    return colr;
endfunction

// 4-bit channel to 8 bits by repeating the nibble
function automatic dvi_chan_t nibble_to_byte(input chan_t n);
    return {n, n};
endfunction

// compare one value, print a line on mismatch
task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks_done = checks_done + 1;
    if (act !== exp) begin
        errors_seen = errors_seen + 1;
        $display("error at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
    end
endtask

`endif

// ==== sim/tb_rasterbars.sv ====
/*
 * self-checking testbench for rasterbars_top
 * runs three frames, switches the palette mid frame 1, checks every output cycle
 */

`timescale 1ns/10ps

module tb_rasterbars
    import raster_pkg::*;
();

    localparam int LINE_CYC  = int'(H_TOTAL);              // cycles per line
    localparam int FRAME_CYC = LINE_CYC * int'(V_TOTAL);   // cycles per frame
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYC + 1000;
    localparam int SWITCH_K  = (int'(V_RES) / 2) * LINE_CYC;  // palette switch point in mid frame 1

    logic      clk_pix;
    logic      rst;
    logic      palette_gold;
    dvi_chan_t dvi_r;
    dvi_chan_t dvi_g;
    dvi_chan_t dvi_b;
    logic      dvi_hsync;
    logic      dvi_vsync;
    logic      dvi_de;

    int k = 0;           // clock edges since reset released
    int rst_edges = 0;   // clock edges seen with reset high
    int gold_frame = 0;  // first frame that starts gold or 0 while none
    int tests_done = 0;
    int phase_checks = 0;
    int phase_errors = 0;

    `include "tb_model.svh"

    rasterbars_top uut (
        .clk_pix      (clk_pix),
        .rst          (rst),
        .palette_gold (palette_gold),
        .dvi_r        (dvi_r),
        .dvi_g        (dvi_g),
        .dvi_b        (dvi_b),
        .dvi_hsync    (dvi_hsync),
        .dvi_vsync    (dvi_vsync),
        .dvi_de       (dvi_de)
    );

    initial clk_pix = 1'b0;
    always #5 clk_pix = ~clk_pix;  // 10 ns period

    // raster position counted from the clock alone
    always @(posedge clk_pix) begin
        if (rst) begin
            k         <= 0;
            rst_edges <= rst_edges + 1;
        end else begin
            k <= k + 1;
        end
    end

    // start colour of a frame from the palette schedule
    function automatic colr_t start_colour_for(input int frame);
        return (gold_frame > 0 && frame >= gold_frame) ? COLR_GOLD : COLR_BLUE;
    endfunction

    // print one test summary and open the next
    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checks_done - phase_checks, errors_seen - phase_errors);
        phase_checks = checks_done;
        phase_errors = errors_seen;
        tests_done   = tests_done + 1;
    endtask

    // reset then palette switch half way down frame 1
    initial begin : stimulus
        rst          = 1'b1;
        palette_gold = 1'b0;
        repeat (3) @(posedge clk_pix);
        #1 rst = 1'b0;
        while (k < SWITCH_K) begin
            @(posedge clk_pix);
            #1;
        end
        palette_gold = 1'b1;            // taken at the end of frame 1
        gold_frame   = k / FRAME_CYC + 2;
    end

    // watchdog
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_pix);
            cycles = cycles + 1;
        end
        $display("timeout: run did not reach the end of frame 3 within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // compare every output cycle on the falling edge where outputs are stable
    initial begin : compare
        int        q;              // raster position shown at the outputs
        int        px;
        int        ln;
        int        frame;
        logic      e_de;
        logic      e_hs;
        logic      e_vs;
        colr_t     e_colr;
        colr_t     line_colr;      // reference colour of the current line
        int        cache_ln;
        int        cache_frame;
        logic      prev_de;
        logic      prev_hs;
        logic      prev_vs;
        int        de_run;
        int        hs_run;
        int        vs_run;
        int        de_fall_q;      // position of the last de fall or -1 once used
        int        hs_rise_q;      // position of the last hsync rise
        int        active_lines;
        int        first_de_k;
        logic      short_line;     // first line after reset starts at column 1
        logic      done;
        colr_t     sig2 [0:1023];  // expected line colours of frame 2
        cache_ln = -1;
        cache_frame = -1;
        line_colr = '0;
        prev_de = 1'b0;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        de_run = 0;
        hs_run = 0;
        vs_run = 0;
        de_fall_q = -1;
        hs_rise_q = -1;
        active_lines = 0;
        first_de_k = -1;
        short_line = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_pix);
            if (rst_edges > 0) begin
                q = k - 1;
                px = 0;
                ln = 0;
                frame = 0;
                e_de = 1'b0;  // idle during reset and one cycle after
                e_hs = ~SYNC_POL;
                e_vs = ~SYNC_POL;
                e_colr = '0;
                if (k >= 2) begin
                    px    = q % LINE_CYC;
                    ln    = (q / LINE_CYC) % int'(V_TOTAL);
                    frame = q / FRAME_CYC + 1;
                    e_de  = (px < int'(H_RES)) && (ln < int'(V_RES));
                    e_hs  = (px >= int'(H_RES + H_FP) && px < int'(H_RES + H_FP + H_SYNC))
                            ? SYNC_POL : ~SYNC_POL;
                    e_vs  = (ln >= int'(V_RES + V_FP) && ln < int'(V_RES + V_FP + V_SYNC))
                            ? SYNC_POL : ~SYNC_POL;
                    if (ln < int'(V_RES) && (ln != cache_ln || frame != cache_frame)) begin
                        line_colr   = bar_colour_ref(ln, start_colour_for(frame));
                        cache_ln    = ln;
                        cache_frame = frame;
                    end
                    e_colr = e_de ? line_colr : '0;  // black in blanking
                end
                check_value("dvi_de", e_de, dvi_de);
                check_value("dvi_hsync", e_hs, dvi_hsync);
                check_value("dvi_vsync", e_vs, dvi_vsync);
                check_value("dvi_r", nibble_to_byte(e_colr[11:8]), dvi_r);
                check_value("dvi_g", nibble_to_byte(e_colr[7:4]), dvi_g);
                check_value("dvi_b", nibble_to_byte(e_colr[3:0]), dvi_b);

                if (dvi_de && first_de_k < 0) first_de_k = k;

                if (k >= 2) begin
                    // de run length per line and active lines per frame
                    if (dvi_de) begin
                        de_run = prev_de ? de_run + 1 : 1;
                        if (!prev_de) active_lines = active_lines + 1;
                    end else if (prev_de) begin
                        if (!short_line) check_value("dvi_de high cycles", H_RES, de_run);
                        short_line = 1'b0;
                        de_fall_q  = q;
                    end
                    // hsync placement, width and line period
                    if (dvi_hsync) begin
                        hs_run = prev_hs ? hs_run + 1 : 1;
                        if (!prev_hs) begin
                            if (de_fall_q >= 0) begin
                                check_value("de fall to hsync", H_FP, q - de_fall_q);
                            end
                            if (hs_rise_q >= 0) check_value("line period", H_TOTAL, q - hs_rise_q);
                            de_fall_q = -1;
                            hs_rise_q = q;
                        end
                    end else if (prev_hs) begin
                        check_value("dvi_hsync high cycles", H_SYNC, hs_run);
                    end
                    // vsync width and active line count
                    if (dvi_vsync) begin
                        vs_run = prev_vs ? vs_run + 1 : 1;
                        if (!prev_vs) begin
                            check_value("active lines per frame", V_RES, active_lines);
                            active_lines = 0;
                        end
                    end else if (prev_vs) begin
                        check_value("dvi_vsync high cycles", int'(V_SYNC) * LINE_CYC, vs_run);
                    end
                    // expected frame 2 line colours kept for the repeat check in frame 3
                    if (px == 0 && ln < int'(V_RES)) begin
                        if (frame == 2) sig2[ln] = line_colr;
                        if (frame == 3) begin
                            check_value("frame 3 line vs frame 2",
                                        {nibble_to_byte(sig2[ln][11:8]),
                                         nibble_to_byte(sig2[ln][7:4]),
                                         nibble_to_byte(sig2[ln][3:0])},
                                        {dvi_r, dvi_g, dvi_b});
                        end
                    end
                end

                if (k == 2) begin
                    check_value("first dvi_de rise cycle", 2, first_de_k);
                    report_test("reset and first data enable");
                end
                if (q == FRAME_CYC - 1) report_test("frame 1 blue bars across palette switch");
                if (q == 2 * FRAME_CYC - 1) report_test("frame 2 gold bars from line 0");
                if (q == 3 * FRAME_CYC - 1) begin
                    report_test("frame 3 repeat of frame 2");
                    done = 1'b1;
                end
                prev_de = dvi_de;
                prev_hs = dvi_hsync;
                prev_vs = dvi_vsync;
            end
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks_done,
                 errors_seen);
        if (errors_seen == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src/rasterbars_top.sv ====
/*
 * raster-bar demo top, pixel-clock domain only
 * timing feeds the bar generator, both feed the registered output stage
 */

`timescale 1ns/10ps

module rasterbars_top
    import raster_pkg::*;
(
    input  logic      clk_pix,       // pixel clock, 74.25 MHz in hardware
    input  logic      rst,           // sync reset, active high
    input  logic      palette_gold,  // bar palette, taken at frame restart
    output dvi_chan_t dvi_r,
    output dvi_chan_t dvi_g,
    output dvi_chan_t dvi_b,
    output logic      dvi_hsync,
    output logic      dvi_vsync,
    output logic      dvi_de
);

    // raster position and sync from the timing block
    coord_t sx;
    coord_t sy;
    logic   hsync;
    logic   vsync;
    logic   de;

    colr_t bar_colr;  // current bar colour

    display_timing display_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    // new colour is set up in the blanking after each line
    bar_colour bars_inst (
        .clk_pix      (clk_pix),
        .rst          (rst),
        .sx           (sx),
        .sy           (sy),
        .palette_gold (palette_gold),
        .bar_colr     (bar_colr)
    );

    // one cycle behind the raster
    video_out out_inst (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .bar_colr  (bar_colr),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de)
    );

endmodule

// ==== src/video_out.sv ====
/*
 * output stage, blanks colour outside the active area and widens to 8 bits
 * one register stage keeps colour, sync and de aligned at the pins
 */

`timescale 1ns/10ps

module video_out
    import raster_pkg::*;
(
    input  logic      clk_pix,
    input  logic      rst,
    input  colr_t     bar_colr,   // 12-bit paint colour
    input  logic      de,
    input  logic      hsync,
    input  logic      vsync,
    output dvi_chan_t dvi_r,
    output dvi_chan_t dvi_g,
    output dvi_chan_t dvi_b,
    output logic      dvi_hsync,
    output logic      dvi_vsync,
    output logic      dvi_de
);

    chan_t paint_r;    // raw channels
    chan_t paint_g;
    chan_t paint_b;
    chan_t display_r;  // black in blanking
    chan_t display_g;
    chan_t display_b;

    // repeat the nibble so 4'hf maps to 8'hff
    function automatic dvi_chan_t widen(input chan_t c);
        widen = {c, c};
    endfunction

    assign {paint_r, paint_g, paint_b} = bar_colr;

    always_comb begin
        display_r = de ? paint_r : '0;
        display_g = de ? paint_g : '0;
        display_b = de ? paint_b : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
            dvi_hsync <= ~SYNC_POL;  // idle level
            dvi_vsync <= ~SYNC_POL;
            dvi_de    <= 1'b0;
        end else begin
            dvi_r     <= widen(display_r);
            dvi_g     <= widen(display_g);
            dvi_b     <= widen(display_b);
            dvi_hsync <= hsync;
            dvi_vsync <= vsync;
            dvi_de    <= de;
        end
    end

endmodule
